//--- design/tlu_cfg_if.sv
/*
 * configuration and status link
 * register bank settings out to the trigger blocks, counters back
 */
`timescale 1ns/1ns
`default_nettype none

interface tlu_cfg_if;
    import tlu_pkg::*;

    // all in the BUS_CLK domain
    logic [trig_width-1:0] trig_select;
    logic [trig_width-1:0] veto_select;
    logic [trig_width-1:0] trig_invert;
    logic                  conf_enable;
    logic                  write_ts;    // timestamp instead of counter
    logic [31:0]           counter_max; // 0 means no limit
    logic                  counter_set;
    logic [31:0]           counter_set_value;
    logic                  soft_rst;
    logic [31:0]           trigger_counter;
    cfg_byte_t             lost_cnt;

    modport regs (
        output trig_select, veto_select, trig_invert, conf_enable, write_ts,
        output counter_max, counter_set, counter_set_value, soft_rst,
        input  trigger_counter, lost_cnt
    );

    modport input_side (input trig_select, veto_select, trig_invert, soft_rst);

    modport fsm (
        input  conf_enable, write_ts, counter_max, counter_set, counter_set_value, soft_rst,
        output trigger_counter
    );

    modport fifo (input soft_rst, output lost_cnt);

endinterface

`default_nettype wire

//--- design/tlu_controller_top.sv
/*
 * trigger controller top level
 * register bank, input stage, acceptance FSM and output FIFO on one clock
 */
`timescale 1ns/1ns
`default_nettype none

module tlu_controller_top #(
    parameter int abus_width = 16,
    parameter int fifo_depth = 8
) (
    input  wire                           BUS_CLK,
    input  wire                           RST,
    input  wire [abus_width-1:0]          BUS_ADD,
    input  wire tlu_pkg::cfg_byte_t       BUS_DATA_IN,
    input  wire                           BUS_RD,
    input  wire                           BUS_WR,
    output tlu_pkg::cfg_byte_t            BUS_DATA_OUT,
    input  wire [tlu_pkg::trig_width-1:0] TRIGGER,
    input  wire [tlu_pkg::trig_width-1:0] TRIGGER_VETO,
    input  wire                           TRIGGER_ENABLE,
    input  wire                           TRIGGER_ACKNOWLEDGE,
    output logic                          TRIGGER_ACCEPTED_FLAG,
    input  wire                           FIFO_READ,
    output logic                          FIFO_EMPTY,
    output tlu_pkg::word_t                FIFO_DATA,
    output tlu_pkg::word_t                TIMESTAMP
);
    import tlu_pkg::*;

    logic  trigger_level;
    logic  trigger_flag;
    logic  veto;
    logic  data_write;
    word_t data_word;

    tlu_cfg_if cfg_if ();

    tlu_reg_bank #(
        .abus_width(abus_width)
    ) tlu_reg_bank_i (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .BUS_ADD(BUS_ADD),
        .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_RD(BUS_RD),
        .BUS_WR(BUS_WR),
        .BUS_DATA_OUT(BUS_DATA_OUT),
        .cfg(cfg_if.regs)
    );

    trigger_input_stage trigger_input_stage_i (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .trigger(TRIGGER),
        .trigger_veto(TRIGGER_VETO),
        .cfg(cfg_if.input_side),
        .trigger_level(trigger_level),
        .trigger_flag(trigger_flag),
        .veto(veto)
    );

    trigger_fsm trigger_fsm_i (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .trigger_level(trigger_level),
        .trigger_flag(trigger_flag),
        .veto(veto),
        .trigger_enable(TRIGGER_ENABLE),
        .trigger_acknowledge(TRIGGER_ACKNOWLEDGE),
        .cfg(cfg_if.fsm),
        .trigger_accepted_flag(TRIGGER_ACCEPTED_FLAG),
        .data_write(data_write),
        .data_word(data_word),
        .timestamp(TIMESTAMP)
    );

    trigger_data_fifo #(
        .fifo_depth(fifo_depth)
    ) trigger_data_fifo_i (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .data_write(data_write),
        .data_word(data_word),
        .fifo_read(FIFO_READ),
        .fifo_empty(FIFO_EMPTY),
        .fifo_data(FIFO_DATA),
        .cfg(cfg_if.fifo)
    );

endmodule

`default_nettype wire

//--- design/tlu_pkg.sv
/*
 * tlu package
 * shared constants, register map and word types of the trigger controller
 */
`default_nettype none

package tlu_pkg;

    typedef logic [7:0]  cfg_byte_t;   // one register byte
    typedef logic [31:0] word_t;       // bit 31 marker, 30:0 payload
    typedef logic [4:0]  reg_addr_t;   // register index on the bus

    localparam cfg_byte_t tlu_version = 8'd6;
    localparam int trig_width = 8;     // trigger and veto inputs

    // configuration bit positions
    localparam int conf1_enable_bit = 3;
    localparam int conf2_write_ts_bit = 7;

    // register map
    localparam reg_addr_t addr_reset_version = 5'd0;
    localparam reg_addr_t addr_conf1 = 5'd1;
    localparam reg_addr_t addr_conf2 = 5'd2;
    localparam reg_addr_t addr_trig_cnt0 = 5'd8;
    localparam reg_addr_t addr_trig_cnt1 = 5'd9;
    localparam reg_addr_t addr_trig_cnt2 = 5'd10;
    localparam reg_addr_t addr_trig_cnt3 = 5'd11;
    localparam reg_addr_t addr_lost_cnt = 5'd12;
    localparam reg_addr_t addr_trig_select = 5'd13;
    localparam reg_addr_t addr_veto_select = 5'd14;
    localparam reg_addr_t addr_trig_invert = 5'd15;
    localparam reg_addr_t addr_trig_max0 = 5'd16;
    localparam reg_addr_t addr_trig_max1 = 5'd17;
    localparam reg_addr_t addr_trig_max2 = 5'd18;
    localparam reg_addr_t addr_trig_max3 = 5'd19;

endpackage

`default_nettype wire

//--- design/tlu_reg_bank.sv
/*
 * tlu register bank
 * byte wide bus registers, registered readback, soft reset on address 0
 * and the trigger counter preset
 */
`timescale 1ns/1ns
`default_nettype none

module tlu_reg_bank #(
    parameter int abus_width = 16
) (
    input  wire                     BUS_CLK,
    input  wire                     RST,
    input  wire [abus_width-1:0]    BUS_ADD,
    input  wire tlu_pkg::cfg_byte_t BUS_DATA_IN,
    input  wire                     BUS_RD,
    input  wire                     BUS_WR,
    output tlu_pkg::cfg_byte_t      BUS_DATA_OUT,
    tlu_cfg_if.regs                 cfg
);
    import tlu_pkg::*;

    logic                  rst;
    logic                  addr_ok;     // upper address bits clear
    reg_addr_t             addr;
    logic                  conf_enable;
    logic                  write_ts;
    logic [trig_width-1:0] trig_select;
    logic [trig_width-1:0] veto_select;
    logic [trig_width-1:0] trig_invert;
    logic [2:0][7:0]       cnt_preset;  // bytes 8 to 10
    logic [3:0][7:0]       trig_max;    // bytes 16 to 19
    logic                  counter_set;
    logic [31:0]           counter_set_value;
    logic [31:8]           cnt_buf;     // upper counter bytes, frozen on read of byte 0

    assign addr = BUS_ADD[4:0];
    assign addr_ok = (BUS_ADD[abus_width-1:5] == '0);
    assign cfg.soft_rst = BUS_WR && addr_ok && (addr == addr_reset_version);
    assign rst = RST | cfg.soft_rst;

    assign cfg.conf_enable = conf_enable;
    assign cfg.write_ts = write_ts;
    assign cfg.trig_select = trig_select;
    assign cfg.veto_select = veto_select;
    assign cfg.trig_invert = trig_invert;
    assign cfg.counter_max = trig_max;
    assign cfg.counter_set = counter_set;
    assign cfg.counter_set_value = counter_set_value;

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            conf_enable <= 1'b0;
            write_ts <= 1'b0;
            trig_select <= '0;
            veto_select <= '1;  // every veto active by default
            trig_invert <= '0;
            cnt_preset <= '0;
            trig_max <= '0;
        end
        else if (BUS_WR && addr_ok)
        begin
            // low two address bits index the multi-byte fields
            case (addr)
                addr_conf1: conf_enable <= BUS_DATA_IN[conf1_enable_bit];
                addr_conf2: write_ts <= BUS_DATA_IN[conf2_write_ts_bit];
                addr_trig_cnt0, addr_trig_cnt1, addr_trig_cnt2:
                    cnt_preset[addr[1:0]] <= BUS_DATA_IN;
                addr_trig_select: trig_select <= BUS_DATA_IN;
                addr_veto_select: veto_select <= BUS_DATA_IN;
                addr_trig_invert: trig_invert <= BUS_DATA_IN;
                addr_trig_max0, addr_trig_max1, addr_trig_max2, addr_trig_max3:
                    trig_max[addr[1:0]] <= BUS_DATA_IN;
                default: ;
            endcase
        end
    end

    // top byte write loads the whole preset
    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
            counter_set <= 1'b0;
        else
            counter_set <= BUS_WR && addr_ok && (addr == addr_trig_cnt3);
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (BUS_WR && addr_ok && (addr == addr_trig_cnt3))
            counter_set_value <= {BUS_DATA_IN, cnt_preset};
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (BUS_RD && addr_ok && (addr == addr_trig_cnt0))
            cnt_buf <= cfg.trigger_counter[31:8];
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (BUS_RD)
        begin
            if (!addr_ok)
                BUS_DATA_OUT <= '0;
            else
            begin
                case (addr)
                    addr_reset_version: BUS_DATA_OUT <= tlu_version;
                    addr_conf1: BUS_DATA_OUT <= cfg_byte_t'(conf_enable) << conf1_enable_bit;
                    addr_conf2: BUS_DATA_OUT <= cfg_byte_t'(write_ts) << conf2_write_ts_bit;
                    addr_trig_cnt0: BUS_DATA_OUT <= cfg.trigger_counter[7:0];
                    addr_trig_cnt1: BUS_DATA_OUT <= cnt_buf[15:8];
                    addr_trig_cnt2: BUS_DATA_OUT <= cnt_buf[23:16];
                    addr_trig_cnt3: BUS_DATA_OUT <= cnt_buf[31:24];
                    addr_lost_cnt: BUS_DATA_OUT <= cfg.lost_cnt;
                    addr_trig_select: BUS_DATA_OUT <= trig_select;
                    addr_veto_select: BUS_DATA_OUT <= veto_select;
                    addr_trig_invert: BUS_DATA_OUT <= trig_invert;
                    addr_trig_max0, addr_trig_max1, addr_trig_max2, addr_trig_max3:
                        BUS_DATA_OUT <= trig_max[addr[1:0]];
                    default: BUS_DATA_OUT <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- design/trigger_data_fifo.sv
/*
 * trigger data FIFO
 * show-ahead circular buffer, words arriving while full are dropped
 * and counted in a saturating lost-word counter
 */
`timescale 1ns/1ns
`default_nettype none

module trigger_data_fifo #(
    parameter int fifo_depth = 8
) (
    input  wire                 BUS_CLK,
    input  wire                 RST,
    input  wire                 data_write,
    input  wire tlu_pkg::word_t data_word,
    input  wire                 fifo_read,
    output logic                fifo_empty,
    output tlu_pkg::word_t      fifo_data,
    tlu_cfg_if.fifo             cfg
);
    import tlu_pkg::*;

    localparam int ptr_w = $clog2(fifo_depth);

    word_t            mem [fifo_depth];
    logic             rst;
    logic [ptr_w-1:0] wr_ptr, rd_ptr;  // wrap on a power-of-two depth
    logic [ptr_w:0]   fill;
    logic             full;
    logic             push, pop;
    cfg_byte_t        lost_cnt;

    assign rst = RST | cfg.soft_rst;
    assign full = (fill == (ptr_w + 1)'(fifo_depth));
    assign fifo_empty = (fill == '0);
    assign push = data_write && !full;
    assign pop = fifo_read && !fifo_empty;
    assign fifo_data = mem[rd_ptr];
    assign cfg.lost_cnt = lost_cnt;

    always_ff @(posedge BUS_CLK)
    begin
        if (push)
            mem[wr_ptr] <= data_word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
            lost_cnt <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            fill <= fill + (ptr_w + 1)'(push) - (ptr_w + 1)'(pop);
            if (data_write && full && lost_cnt != 8'hFF)
                lost_cnt <= lost_cnt + 8'd1;  // saturates at 255
        end
    end

    a_fill_bound: assert property (
        @(posedge BUS_CLK) disable iff (rst) fill <= fifo_depth
    );

endmodule

`default_nettype wire

//--- design/trigger_fsm.sv
/*
 * trigger acceptance FSM
 * accepts a rising trigger when enabled, not vetoed and below the limit,
 * counts it and builds the data word for the output FIFO
 */
`timescale 1ns/1ns
`default_nettype none

module trigger_fsm (
    input  wire                  BUS_CLK,
    input  wire                  RST,
    input  wire                  trigger_level,
    input  wire                  trigger_flag,
    input  wire                  veto,
    input  wire                  trigger_enable,
    input  wire                  trigger_acknowledge,
    tlu_cfg_if.fsm               cfg,
    output logic                 trigger_accepted_flag,
    output logic                 data_write,
    output tlu_pkg::word_t       data_word,
    output tlu_pkg::word_t       timestamp
);
    import tlu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_wait_low
    } state_t;

    state_t      state;
    logic        rst;
    logic        below_max;
    logic        enabled;
    logic        accept;
    logic [31:0] trig_cnt;

    assign rst = RST | cfg.soft_rst;
    assign cfg.trigger_counter = trig_cnt;

    assign below_max = (cfg.counter_max == '0) || (trig_cnt < cfg.counter_max);
    assign enabled = (trigger_enable | cfg.conf_enable) & below_max;
    assign accept = (state == st_idle) && trigger_flag && enabled && !veto;

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            state <= st_idle;
            trigger_accepted_flag <= 1'b0;
            data_write <= 1'b0;
        end
        else
        begin
            trigger_accepted_flag <= accept;
            data_write <= accept;
            case (state)
                st_idle:
                    if (accept)
                        state <= st_wait_ack;
                st_wait_ack:
                    if (trigger_acknowledge)
                        state <= st_wait_low;
                st_wait_low:
                    if (!trigger_level)  // no retrigger on a held input
                        state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
            trig_cnt <= '0;
        else if (cfg.counter_set)
            trig_cnt <= cfg.counter_set_value;
        else if (accept)
            trig_cnt <= trig_cnt + 32'd1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
            timestamp <= '0;
        else
            timestamp <= timestamp + 32'd1;  // free running
    end

    // marker bit set, payload is the count before this trigger
    always_ff @(posedge BUS_CLK)
    begin
        if (accept)
            data_word <= {1'b1, cfg.write_ts ? timestamp[30:0] : trig_cnt[30:0]};
    end

    a_write_with_flag: assert property (
        @(posedge BUS_CLK) disable iff (rst) data_write == trigger_accepted_flag
    );

endmodule

`default_nettype wire

//--- design/trigger_input_stage.sv
/*
 * trigger input stage
 * invert, select and OR the trigger and veto pins, synchronize both
 * and form a one-cycle pulse on the rising trigger
 */
`timescale 1ns/1ns
`default_nettype none

module trigger_input_stage (
    input  wire                           BUS_CLK,
    input  wire                           RST,
    input  wire [tlu_pkg::trig_width-1:0] trigger,
    input  wire [tlu_pkg::trig_width-1:0] trigger_veto,
    tlu_cfg_if.input_side                 cfg,
    output logic                          trigger_level,
    output logic                          trigger_flag,
    output logic                          veto
);
    import tlu_pkg::*;

    logic       rst;
    logic       trig_or;
    logic       veto_or;
    logic [1:0] sync_0, sync_1, sync_2;  // {veto, trigger}
    logic       level_d;

    assign rst = RST | cfg.soft_rst;

    assign trig_or = |((trigger ^ cfg.trig_invert) & cfg.trig_select);
    assign veto_or = |(trigger_veto & cfg.veto_select);

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            sync_0 <= '0;
            sync_1 <= '0;
            sync_2 <= '0;
            level_d <= 1'b0;
            trigger_flag <= 1'b0;
        end
        else
        begin
            sync_0 <= {veto_or, trig_or};  // async pins enter here
            sync_1 <= sync_0;
            sync_2 <= sync_1;
            level_d <= trigger_level;
            trigger_flag <= trigger_level & ~level_d;
        end
    end

    assign trigger_level = sync_2[0];
    assign veto = sync_2[1];

    // a held trigger must give a single pulse
    a_flag_single: assert property (
        @(posedge BUS_CLK) disable iff (rst) trigger_flag |=> !trigger_flag
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the trigger controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tlu_controller_tb -f tlu_controller.f -o tlu_controller_sim

./obj_dir/tlu_controller_sim | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
else
    exit 1
fi

//--- tests/tlu_controller_tb.sv
/*
 * trigger controller testbench
 * runs the steps of the stimulus file against the DUT, answers accepted
 * triggers with a delayed acknowledge and reports each test
 */
`timescale 1ns/1ns
`default_nettype none

module tlu_controller_tb;

    logic        BUS_CLK;
    logic        RST;
    logic [15:0] BUS_ADD;
    logic [7:0]  BUS_DATA_IN;
    logic [7:0]  BUS_DATA_OUT;
    logic        BUS_RD;
    logic        BUS_WR;
    logic [7:0]  TRIGGER;
    logic [7:0]  TRIGGER_VETO;
    logic        TRIGGER_ENABLE;
    logic        TRIGGER_ACKNOWLEDGE;
    logic        TRIGGER_ACCEPTED_FLAG;
    logic        FIFO_READ;
    logic        FIFO_EMPTY;
    logic [31:0] FIFO_DATA;
    logic [31:0] TIMESTAMP;

    string  test_name;
    int     test_errors;
    int     total_errors;
    int     checks;
    int     tests_run;
    int     flag_count;   // accepted flags seen in the current step
    int     ack_cnt;      // cycles left until the acknowledge
    integer seed;

    tlu_controller_top tlu_controller_top_i (.*);

    initial
    begin
        BUS_CLK = 1'b0;
        forever #5 BUS_CLK = ~BUS_CLK;
    end

    // advance to the next falling edge, count flags and answer them
    task automatic step_cycle();
        @(negedge BUS_CLK);
        TRIGGER_ACKNOWLEDGE = 1'b0;
        if (ack_cnt > 0)
        begin
            ack_cnt = ack_cnt - 1;
            TRIGGER_ACKNOWLEDGE = (ack_cnt == 0);
        end
        if (TRIGGER_ACCEPTED_FLAG)
        begin
            flag_count = flag_count + 1;
            ack_cnt = 1 + ($random(seed) & 7);  // 1 to 8 cycles
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] got);
        checks = checks + 1;
        assert (got === exp)
        else
        begin
            $display("Mismatch in test %s, %s: expected %h, actual %h",
                     test_name, what, exp, got);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Error in test %s: %s", test_name, msg);
        test_errors = test_errors + 1;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        step_cycle();
        BUS_ADD = addr;
        BUS_DATA_IN = data;
        BUS_WR = 1'b1;
        step_cycle();
        BUS_WR = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        step_cycle();
        BUS_ADD = addr;
        BUS_RD = 1'b1;
        step_cycle();
        BUS_RD = 1'b0;
        data = BUS_DATA_OUT;  // valid one cycle after the strobe
    endtask

    task automatic run_pulses(input logic [7:0] trig, input logic [7:0] vetos,
                              input int count);
        int p;
        int c;
        for (p = 0; p < count; p++)
        begin
            TRIGGER = trig;
            TRIGGER_VETO = vetos;
            for (c = 0; c < 15; c++)
                step_cycle();
            TRIGGER = '0;
            TRIGGER_VETO = '0;
            for (c = 0; c < 15; c++)
                step_cycle();
        end
    endtask

    task automatic hold_level(input logic [7:0] trig, input logic [7:0] vetos);
        int c;
        TRIGGER = trig;
        TRIGGER_VETO = vetos;
        for (c = 0; c < 30; c++)
            step_cycle();
    endtask

    task automatic pop_word(output logic [31:0] word, output logic ok);
        int wait_cycles;
        wait_cycles = 0;
        while (FIFO_EMPTY && wait_cycles < 50)
        begin
            step_cycle();
            wait_cycles = wait_cycles + 1;
        end
        ok = !FIFO_EMPTY;
        word = FIFO_DATA;
        checks = checks + 1;
        assert (ok)
        else
            report_failure("FIFO stayed empty, no word to read");
        if (ok)
        begin
            FIFO_READ = 1'b1;
            step_cycle();
            FIFO_READ = 1'b0;
        end
    endtask

    task automatic run_step(input logic [8*8-1:0] op, input logic [31:0] a0,
                            input logic [31:0] a1, input logic [31:0] a2,
                            input logic [31:0] exp);
        logic [7:0]  rd_byte;
        logic [31:0] word;
        logic [31:0] ts_before;
        logic [31:0] ts_after;
        logic        ok;
        int          i;
        flag_count = 0;
        case (op)
            "wr": bus_write(a0[15:0], a1[7:0]);
            "rd":
            begin
                bus_read(a0[15:0], rd_byte);
                check_value($sformatf("read of address %0h", a0), exp, {24'h0, rd_byte});
            end
            "rd32":
            begin
                word = '0;
                for (i = 0; i < 4; i++)
                begin
                    bus_read(a0[15:0] + 16'(i), rd_byte);
                    word[8*i +: 8] = rd_byte;  // byte 0 first so the upper bytes get latched
                end
                check_value("32-bit read", exp, word);
            end
            "pulse":
            begin
                run_pulses(a0[7:0], a1[7:0], int'(a2));
                check_value("accepted flags", exp, flag_count);
            end
            "level":
            begin
                hold_level(a0[7:0], a1[7:0]);
                check_value("accepted flags", exp, flag_count);
            end
            "pop":
            begin
                pop_word(word, ok);
                if (ok)
                    check_value("FIFO word", exp, word);
            end
            "popseq":
                for (i = 0; i < int'(a2); i++)
                begin
                    pop_word(word, ok);
                    if (ok)
                        check_value($sformatf("FIFO word %0d", i), exp + 32'(i), word);
                end
            "empty":
            begin
                step_cycle();
                check_value("FIFO empty", exp, {31'h0, FIFO_EMPTY});
            end
            "stamp":
            begin
                ts_before = TIMESTAMP;
                run_pulses(a0[7:0], 8'h00, 1);
                ts_after = TIMESTAMP;
                // one pulse spans 30 clock cycles
                check_value("timestamp advance", 32'd30, ts_after - ts_before);
                check_value("accepted flags", exp, flag_count);
                pop_word(word, ok);
                if (ok)
                begin
                    checks = checks + 1;
                    assert (word[31] && word[30:0] >= ts_before[30:0]
                            && word[30:0] <= ts_after[30:0])
                    else
                        report_failure($sformatf("word %h is no timestamp between %h and %h",
                                                 word, ts_before, ts_after));
                end
            end
            default: report_failure($sformatf("unknown operation %0s", op));
        endcase
    endtask

    task automatic finish_test();
        if (test_errors == 0)
            $display("test %s passed", test_name);
        else
            $display("test %s failed with %0d errors", test_name, test_errors);
        total_errors = total_errors + test_errors;
        tests_run = tests_run + 1;
    endtask

    initial
    begin
        logic [8*16-1:0]  name_raw;
        logic [8*8-1:0]   op_raw;
        logic [8*128-1:0] skip_line;
        logic [31:0]      a0;
        logic [31:0]      a1;
        logic [31:0]      a2;
        logic [31:0]      exp;
        int               fd;
        int               n;
        seed = 32'hc632_1761;
        test_name = "";
        test_errors = 0;
        total_errors = 0;
        checks = 0;
        tests_run = 0;
        flag_count = 0;
        ack_cnt = 0;
        RST = 1'b1;
        BUS_ADD = '0;
        BUS_DATA_IN = '0;
        BUS_RD = 1'b0;
        BUS_WR = 1'b0;
        TRIGGER = '0;
        TRIGGER_VETO = '0;
        TRIGGER_ENABLE = 1'b0;
        TRIGGER_ACKNOWLEDGE = 1'b0;
        FIFO_READ = 1'b0;
        repeat (4) @(negedge BUS_CLK);
        RST = 1'b0;

        fd = $fopen("tests/tlu_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Error: cannot open the stimulus file tests/tlu_stimulus.txt");
            total_errors = total_errors + 1;
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fscanf(fd, "%s", name_raw);
                if (n == 1)
                begin
                    if (name_raw == "#")
                        n = $fgets(skip_line, fd);  // comment line
                    else
                    begin
                        n = $fscanf(fd, "%s %h %h %h %h", op_raw, a0, a1, a2, exp);
                        if (string'(name_raw) != test_name)
                        begin
                            if (test_name != "")
                                finish_test();
                            test_name = string'(name_raw);
                            test_errors = 0;
                        end
                        if (n == 5)
                            run_step(op_raw, a0, a1, a2, exp);
                        else
                            report_failure("stimulus line has too few fields");
                    end
                end
            end
            $fclose(fd);
            if (test_name != "")
                finish_test();
        end

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, total_errors);
        if (total_errors == 0 && tests_run > 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tlu_stimulus.txt
# columns: test, op, arg0, arg1, arg2, expected; all numbers in hex
# ops: wr addr data, rd addr, rd32 addr, pulse trig veto count, level trig veto,
# pop, popseq (arg2 words from expected up), empty, stamp trig
regs    rd      00 00 00 06
regs    rd      0e 00 00 ff
regs    wr      0d 5a 00 00
regs    rd      0d 00 00 5a
regs    wr      10 67 00 00
regs    rd      10 00 00 67
regs    wr      02 80 00 00
regs    rd      02 00 00 80
regs    wr      00 00 00 00
regs    rd      0d 00 00 00
regs    rd      10 00 00 00
regs    rd      02 00 00 00
regs    rd      0e 00 00 ff
accept  wr      0d 04 00 00
accept  wr      01 08 00 00
accept  pulse   04 00 01 01
accept  pop     00 00 00 80000000
accept  pulse   04 00 01 01
accept  pop     00 00 00 80000001
accept  rd32    08 00 00 00000002
select  wr      00 00 00 00
select  wr      0d 04 00 00
select  wr      01 08 00 00
select  pulse   08 00 01 00
select  wr      0e 02 00 00
select  pulse   04 02 01 00
select  pulse   04 01 01 01
select  level   20 00 00 00
select  wr      0f 20 00 00
select  wr      0d 20 00 00
select  level   00 00 00 01
select  level   20 00 00 00
limit   wr      00 00 00 00
limit   wr      0d 04 00 00
limit   wr      01 08 00 00
limit   wr      08 64 00 00
limit   wr      09 00 00 00
limit   wr      0a 00 00 00
limit   wr      0b 00 00 00
limit   wr      10 67 00 00
limit   pulse   04 00 05 03
limit   popseq  00 00 03 80000064
limit   empty   00 00 00 01
overflow wr     00 00 00 00
overflow wr     0d 04 00 00
overflow wr     01 08 00 00
overflow pulse  04 00 0a 0a
overflow rd     0c 00 00 02
overflow popseq 00 00 08 80000000
overflow empty  00 00 00 01
stamp   wr      00 00 00 00
stamp   wr      0d 04 00 00
stamp   wr      01 08 00 00
stamp   wr      02 80 00 00
stamp   stamp   04 00 00 01

//--- tlu_controller.f
design/tlu_pkg.sv
design/tlu_cfg_if.sv
design/tlu_reg_bank.sv
design/trigger_input_stage.sv
design/trigger_fsm.sv
design/trigger_data_fifo.sv
design/tlu_controller_top.sv
tests/tlu_controller_tb.sv
